//--- tb.f
+incdir+.
board_pkg.sv
slow_clk_gen.sv
uart_rx.sv
uart_tx.sv
top.sv
board_specific_top.sv
tb_board_specific_top.sv

//--- Makefile
# Verilator build and run of the board lab testbench.

TOP = tb_board_specific_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP) -o $(TOP)

# Passes only if the pass message shows up in the output.
run: compile
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

//--- tb_uart_tasks.svh
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// Drive one 8N1 frame on RXD, LSB first, one bit per bit time.
task automatic uart_send(input logic [w_byte-1:0] data);
    logic [uart_frame_bits-1:0] frame;
    int                         i;
    frame = {1'b1, data, 1'b0};
    for (i = 0; i < uart_frame_bits; i++) begin
        @(negedge clk);
        RXD = frame[i];
        repeat (uart_clks_per_bit - 1) @(negedge clk);
    end
endtask

// Wait for a start bit on TXD, then sample each bit at its middle.
// got stays low if no start bit shows up within limit cycles.
task automatic uart_recv(input int limit, output logic got, output logic [w_byte-1:0] data);
    int waited;
    int i;
    got = 1'b0;
    data = '0;
    waited = 0;
    while (TXD !== 1'b0 && waited < limit) begin
        @(negedge clk);
        waited++;
    end
    if (TXD === 1'b0) begin
        got = 1'b1;
        // Middle of the start bit.
        repeat (uart_half_bit) @(negedge clk);
        for (i = 0; i < w_byte; i++) begin
            repeat (uart_clks_per_bit) @(negedge clk);
            data[i] = TXD;
        end
        // Return at the middle of the stop bit.
        repeat (uart_clks_per_bit) @(negedge clk);
    end
endtask

// Hold one key down for 20 cycles.
task automatic press_key(input int idx);
    @(negedge clk);
    keys[idx] = 1'b1;
    repeat (20) @(negedge clk);
    keys[idx] = 1'b0;
endtask

`endif

//--- tb_board_specific_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_specific_top;

    import board_pkg::*;

    // Heartbeat shortened to 200 clock cycles per period.
    localparam int hb_period = 200;
    localparam int tb_slow_clk_hz = default_clk_mhz * 1_000_000 / hb_period;

    // Echo window of two frames on the serial line.
    localparam int two_frames = 2 * uart_frame_bits * uart_clks_per_bit;

    logic             clk;
    logic             pll_locked;
    logic             pll_reset_n;
    logic             reset;
    logic [w_key-1:0] keys;
    logic [w_sw-1:0]  sw;
    logic [w_led-1:0] led_n;
    logic             RXD;
    logic             TXD;

    int errors;
    int checks;
    int tests;
    int failed_tests;
    // Error count when the current test began.
    int test_errors;

    board_specific_top #(
        .clk_mhz     (default_clk_mhz),
        .slow_clk_hz (tb_slow_clk_hz)
    ) u_board_specific_top (
        .pll_clk     (clk),
        .pll_locked  (pll_locked),
        .pll_reset_n (pll_reset_n),
        .reset       (reset),
        .keys        (keys),
        .sw          (sw),
        .led_n       (led_n),
        .RXD         (RXD),
        .TXD         (TXD)
    );

    `include "tb_uart_tasks.svh"

    // PLL reset must follow the reset button at all times.
    pll_reset_inverse: assert property (@(posedge clk) pll_reset_n == ~reset)
        else begin
            $display("MISMATCH at %0t: pll_reset_n expected %b, actual %b",
                     $time, ~reset, pll_reset_n);
            errors++;
        end

    // 4 ns clock.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Upper bound on the whole run.
    initial begin
        repeat (2_000_000) @(posedge clk);
        $display("Run did not finish within the cycle limit.");
        $display("** FAIL **");
        $finish;
    end

    task automatic compare_value(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
        checks++;
        assert (actual === expected)
            else begin
                $display("MISMATCH at %0t: %s expected %h, actual %h",
                         $time, name, expected, actual);
                errors++;
            end
    endtask

    task automatic check_condition(input logic cond, input string what);
        checks++;
        assert (cond)
            else begin
                $display("ERROR at %0t: %s", $time, what);
                errors++;
            end
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end
    endtask

    // Uppercase model. Letters a to z move down by the case offset.
    function automatic logic [7:0] to_upper(input logic [7:0] b);
        if (b >= "a" && b <= "z")
            return b - ("a" - "A");
        return b;
    endfunction

    // Send one byte and watch TXD for its echo.
    task automatic exchange_byte(input logic [w_byte-1:0] sent,
                                 input logic [w_byte-1:0] expected, input logic echo_on);
        logic              got;
        logic [w_byte-1:0] echoed;
        fork
            uart_send(sent);
            uart_recv(two_frames, got, echoed);
        join
        if (echo_on) begin
            check_condition(got, "no echo start bit appeared on TXD");
            if (got)
                compare_value("TXD byte", expected, echoed);
        end else begin
            check_condition(!got, "a start bit appeared on TXD with echo off");
        end
    endtask

    initial begin
        logic [w_byte-1:0] sent;
        logic [w_byte-1:0] count;
        logic [w_byte-1:0] echoed;
        logic              got;
        int                waited;
        int                i;

        void'($urandom(32'h140a));
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        test_errors = 0;
        pll_locked = 1'b0;
        reset = 1'b1;
        keys = '0;
        sw = '0;
        RXD = 1'b1;

        // Hold reset for 10 cycles. Line idle and LEDs dark once it settles.
        start_test();
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i >= 3) begin
                compare_value("TXD", 8'h01, 8'(TXD));
                compare_value("led_n", '1, led_n);
            end
        end
        reset = 1'b0;
        // Core stays in reset while the PLL is unlocked.
        exchange_byte(8'h5a, 8'h5a, 1'b0);
        compare_value("led_n", '1, led_n);
        finish_test("reset and lock");

        // Lock the PLL. The core leaves reset two cycles later.
        pll_locked = 1'b1;
        repeat (5) @(negedge clk);

        start_test();
        sw = 3'b010;
        for (i = 0; i < 8; i++) begin
            sent = w_byte'($urandom);
            exchange_byte(sent, sent, 1'b1);
            compare_value("led_n", ~sent, led_n);
        end
        finish_test("plain echo");

        // Every other byte is a lowercase letter.
        start_test();
        sw = 3'b011;
        for (i = 0; i < 12; i++) begin
            if (i % 2 == 0)
                sent = "a" + w_byte'($urandom % 26);
            else
                sent = w_byte'($urandom);
            exchange_byte(sent, to_upper(sent), 1'b1);
            compare_value("led_n", ~sent, led_n);
        end
        finish_test("uppercase echo");

        start_test();
        sw = 3'b000;
        sent = w_byte'($urandom);
        exchange_byte(sent, sent, 1'b0);
        compare_value("led_n", ~sent, led_n);
        finish_test("echo off");

        start_test();
        sw = 3'b100;
        // Key 1 clears the count. Watch for zero on the LEDs.
        fork
            press_key(1);
            begin
                waited = 0;
                while (led_n !== '1 && waited < 50) begin
                    @(negedge clk);
                    waited++;
                end
            end
        join
        check_condition(waited < 50, "heartbeat count did not clear on key 1");
        repeat (3 * hb_period) @(negedge clk);
        count = ~led_n;
        // Three periods give a count of 3, or 4 when a rise lands at the edge.
        checks++;
        assert (count == 8'd3 || count == 8'd4)
            else begin
                $display("MISMATCH at %0t: heartbeat count expected 3 or 4, actual %0d",
                         $time, count);
                errors++;
            end

        // Align to a count change so the count holds during the key 0 press.
        count = ~led_n;
        waited = 0;
        while (~led_n == count && waited < 2 * hb_period) begin
            @(negedge clk);
            waited++;
        end
        check_condition(waited < 2 * hb_period, "heartbeat count did not advance");
        count = ~led_n;
        fork
            press_key(0);
            uart_recv(two_frames, got, echoed);
        join
        check_condition(got, "no start bit on TXD after key 0");
        if (got)
            compare_value("TXD byte", count, echoed);
        finish_test("heartbeat and keys");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- board_specific_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_specific_top #(
    parameter int clk_mhz     = board_pkg::default_clk_mhz,
    parameter int slow_clk_hz = board_pkg::default_slow_clk_hz
) (
    input  logic                        pll_clk,
    input  logic                        pll_locked,
    output logic                        pll_reset_n,
    input  logic                        reset,
    input  logic [board_pkg::w_key-1:0] keys,
    input  logic [board_pkg::w_sw-1:0]  sw,
    output logic [board_pkg::w_led-1:0] led_n,
    input  logic                        RXD,
    output logic                        TXD
);

    import board_pkg::*;

    logic             clk;
    logic             rst_meta;
    logic             rst;
    logic             slow_clk;
    logic [w_led-1:0] led;

    // PLL output is the system clock.
    assign clk = pll_clk;

    // PLL reset is active low.
    assign pll_reset_n = ~reset;

    // Core reset held until lock, released two cycles later.
    always_ff @(posedge clk) begin
        if (reset || !pll_locked) begin
            rst_meta <= 1'b1;
            rst      <= 1'b1;
        end else begin
            rst_meta <= 1'b0;
            rst      <= rst_meta;
        end
    end

    slow_clk_gen #(
        .fast_clk_mhz (clk_mhz),
        .slow_clk_hz  (slow_clk_hz)
    ) i_slow_clk_gen (
        .clk      (clk),
        .rst      (rst),
        .slow_clk (slow_clk)
    );

    top i_top (
        .clk      (clk),
        .slow_clk (slow_clk),
        .rst      (rst),
        .key      (keys),
        .sw       (sw),
        .uart_rx  (RXD),
        .led      (led),
        .uart_tx  (TXD)
    );

    // Board LEDs are active low.
    assign led_n = ~led;

endmodule

`default_nettype wire

//--- top.sv
`timescale 1ns/1ps
`default_nettype none

module top (
    input  logic                       clk,
    input  logic                       slow_clk,
    input  logic                       rst,
    input  logic [board_pkg::w_key-1:0] key,
    input  logic [board_pkg::w_sw-1:0]  sw,
    input  logic                       uart_rx,
    output logic [board_pkg::w_led-1:0] led,
    output logic                       uart_tx
);

    import board_pkg::*;

    logic [w_key-1:0]  key_meta;
    logic [w_key-1:0]  key_sync;
    logic [w_key-1:0]  key_prev;
    logic [w_key-1:0]  key_press;
    logic              slow_prev;
    logic              slow_rise;
    logic [w_byte-1:0] hb_cnt;
    logic [w_byte-1:0] rx_data;
    logic              rx_valid;
    logic [w_byte-1:0] rx_last;
    logic [w_byte-1:0] echo_data;
    logic              slot_full;
    logic [w_byte-1:0] slot_data;
    logic              tx_start;
    logic              tx_busy;

    // Keys pass a two-flop synchronizer and a rising edge detect.
    always_ff @(posedge clk) begin
        if (rst) begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    assign key_press = key_sync & ~key_prev;

    // Heartbeat counter advances on each slow clock rise.
    assign slow_rise = slow_clk & ~slow_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            slow_prev <= 1'b0;
            hb_cnt    <= '0;
        end else begin
            slow_prev <= slow_clk;
            // Key 1 clears the count.
            if (key_press[1])
                hb_cnt <= '0;
            else if (slow_rise)
                hb_cnt <= hb_cnt + 1'b1;
        end
    end

    uart_rx i_uart_rx (
        .clk      (clk),
        .rst      (rst),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    // Lowercase to uppercase when sw[0] is set.
    assign echo_data = (sw[0] && rx_data >= "a" && rx_data <= "z") ? rx_data - 8'h20 : rx_data;

    // One-byte send slot. Echo has priority over key 0.
    // Requests arriving while full are dropped.
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_full <= 1'b0;
        end else if (slot_full) begin
            if (!tx_busy)
                slot_full <= 1'b0;
        end else if ((rx_valid && sw[1]) || key_press[0]) begin
            slot_full <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!slot_full) begin
            if (rx_valid && sw[1])
                slot_data <= echo_data;
            else if (key_press[0])
                slot_data <= hb_cnt;
        end
    end

    // Issue as soon as the transmitter is free.
    assign tx_start = slot_full & ~tx_busy;

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (slot_data),
        .tx       (uart_tx),
        .tx_busy  (tx_busy)
    );

    // LED source. sw[2] picks heartbeat, else the last raw byte.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_last <= '0;
            led     <= '0;
        end else begin
            if (rx_valid)
                rx_last <= rx_data;
            if (sw[2])
                led <= hb_cnt;
            else
                led <= rx_valid ? rx_data : rx_last;
        end
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tx_start,
    input  logic [board_pkg::w_byte-1:0] tx_data,
    output logic                        tx,
    output logic                        tx_busy
);

    import board_pkg::*;

    // Last cycle of one bit.
    localparam logic [uart_cnt_w-1:0] bit_last = uart_cnt_w'(uart_clks_per_bit - 1);

    // Bit counter covers the whole frame.
    localparam int bit_w = $clog2(uart_frame_bits);
    localparam logic [bit_w-1:0] frame_last = bit_w'(uart_frame_bits - 1);

    logic [uart_cnt_w-1:0] cnt;
    logic [bit_w-1:0]      bit_cnt;

    // Data bits followed by the stop bit.
    logic [w_byte:0]       shift;

    // Control and line output.
    always_ff @(posedge clk) begin
        if (rst) begin
            tx      <= 1'b1;
            tx_busy <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            cnt     <= '0;
            bit_cnt <= '0;
            if (tx_start) begin
                // Start bit goes out on the next cycle.
                tx      <= 1'b0;
                tx_busy <= 1'b1;
            end
        end else if (cnt == bit_last) begin
            cnt <= '0;
            if (bit_cnt == frame_last) begin
                // End of stop bit.
                tx_busy <= 1'b0;
            end else begin
                tx      <= shift[0];
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Shift register fills with ones behind the stop bit.
    always_ff @(posedge clk) begin
        if (!tx_busy && tx_start)
            shift <= {1'b1, tx_data};
        else if (tx_busy && cnt == bit_last)
            shift <= {1'b1, shift[w_byte:1]};
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        rx,
    output logic [board_pkg::w_byte-1:0] rx_data,
    output logic                        rx_valid
);

    import board_pkg::*;

    // Counter end points for a half bit and a full bit.
    localparam logic [uart_cnt_w-1:0] half_last = uart_cnt_w'(uart_half_bit - 1);
    localparam logic [uart_cnt_w-1:0] bit_last  = uart_cnt_w'(uart_clks_per_bit - 1);

    // Index of the last data bit.
    localparam int idx_w = $clog2(w_byte);
    localparam logic [idx_w-1:0] idx_last = idx_w'(w_byte - 1);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t state;

    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic [uart_cnt_w-1:0] cnt;
    logic [idx_w-1:0]      bit_idx;
    logic [w_byte-1:0]     shift;

    // Two-stage synchronizer plus one stage for edge detect.
    // The line idles high.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Receive FSM.
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                st_idle: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    // Falling edge starts a frame.
                    if (rx_prev && !rx_sync)
                        state <= st_start;
                end
                st_start: begin
                    if (cnt == half_last) begin
                        cnt <= '0;
                        // Still low at mid-bit, else it was a glitch.
                        state <= rx_sync ? st_idle : st_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (cnt == bit_last) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == idx_last)
                            state <= st_stop;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == bit_last) begin
                        cnt   <= '0;
                        state <= st_idle;
                        // Only a high stop bit delivers the byte.
                        rx_valid <= rx_sync;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Data path shifts in the LSB first.
    always_ff @(posedge clk) begin
        if (state == st_data && cnt == bit_last)
            shift <= {rx_sync, shift[w_byte-1:1]};
        if (state == st_stop && cnt == bit_last && rx_sync)
            rx_data <= shift;
    end

endmodule

`default_nettype wire

//--- slow_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module slow_clk_gen #(
    parameter int fast_clk_mhz = board_pkg::default_clk_mhz,
    parameter int slow_clk_hz  = board_pkg::default_slow_clk_hz
) (
    input  logic clk,
    input  logic rst,
    output logic slow_clk
);

    // Fast clock cycles per half period of the heartbeat.
    localparam int half_period = fast_clk_mhz * 1_000_000 / (2 * slow_clk_hz);

    // Counter wide enough for the half period.
    localparam int cnt_w = (half_period > 1) ? $clog2(half_period) : 1;

    // Terminal count of the divider.
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(half_period - 1);

    logic [cnt_w-1:0] cnt;

    // Divider counter and output toggle.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end else if (cnt == cnt_last) begin
            // The output flips at the end of each half period.
            cnt      <= '0;
            slow_clk <= ~slow_clk;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- board_pkg.sv
`default_nettype none

package board_pkg;

    // Board I/O widths.
    localparam int w_key = 2;
    localparam int w_sw  = 3;
    localparam int w_led = 8;

    // UART payload width.
    localparam int w_byte = 8;

    // Default board clock in MHz.
    localparam int default_clk_mhz = 50;

    // Default heartbeat rate in Hz.
    localparam int default_slow_clk_hz = 1;

    // UART line rate.
    localparam int uart_baud = 115200;

    // Clock cycles per serial bit, rounded down.
    localparam int uart_clks_per_bit = default_clk_mhz * 1_000_000 / uart_baud;

    // Offset from a bit edge to its middle.
    localparam int uart_half_bit = uart_clks_per_bit / 2;

    // Width of the per-bit cycle counter.
    localparam int uart_cnt_w = $clog2(uart_clks_per_bit);

    // Start bit, data bits and one stop bit.
    localparam int uart_frame_bits = w_byte + 2;

endpackage

`default_nettype wire
